// ==== dsp_core.f ====
logic/dsp_pkg.sv
logic/dsp_regs_if.sv
logic/dsp_regfile.sv
logic/dsp_alu.sv
logic/dsp_sequencer.sv
logic/dsp_core.sv
verification/dsp_core_tb.sv

// ==== verification/dsp_core_tb.sv ====
`timescale 1ns/1ps

module dsp_core_tb;

	// ~~~~~~~~~~~~~~~~~~~~
	// run limits
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int RESET_CYCLES = 4;
	localparam int WRITE_CYC    = 3;   // worst case per host write.
	localparam int READ_CYC     = 4;   // worst case per host read.
	localparam int INSTR_CYC    = 6;   // worst case per instruction.
	localparam int CASE_CYC     = 2 * WRITE_CYC + INSTR_CYC + READ_CYC;
	localparam int N_RANDOM     = 24;
	localparam int TEST_CYC     = 2 * RESET_CYCLES + 64 * (WRITE_CYC + READ_CYC)
		+ 30 * CASE_CYC + N_RANDOM * (INSTR_CYC + READ_CYC)
		+ 4 * INSTR_CYC + 12 * (WRITE_CYC + READ_CYC);
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYC + 100;
	localparam int WAIT_LIMIT     = 16;  // per handshake.

	logic                sys_clk;
	logic                reset;
	logic                instr_valid;
	dsp_pkg::alu_op_t    op;
	dsp_pkg::reg_addr_t  dst;
	dsp_pkg::reg_addr_t  src;
	logic                host_we;
	logic                host_rd;
	dsp_pkg::reg_addr_t  host_addr;
	dsp_pkg::reg_data_t  host_wdata;
	dsp_pkg::reg_data_t  host_rdata;
	logic                host_rvalid;
	logic                busy;
	logic                done;
	dsp_pkg::alu_flags_t flags;

	dsp_pkg::reg_data_t  model [0:dsp_pkg::REG_COUNT-1];
	dsp_pkg::alu_flags_t exp_flags;
	dsp_pkg::reg_data_t  rd_model;     // word expected by the read being issued.
	dsp_pkg::reg_data_t  rd_model_d1;
	dsp_pkg::reg_data_t  rd_model_d2;
	logic [31:0]         rand_state;
	int                  fail_count;
	int                  test_count;
	int                  cycle_count;
	int                  errs_at_start;

	logic instr_accept;
	logic write_accept;
	logic read_accept;

	assign instr_accept = instr_valid && !busy;
	assign write_accept = host_we && !instr_valid && !busy;
	assign read_accept  = host_rd && !host_we && !instr_valid && !busy;

	dsp_core u_dut (.*);

	always #4 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		rd_model_d1 <= rd_model;
		rd_model_d2 <= rd_model_d1;  // lines up with host_rvalid.
	end

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~
	function void note_failure(input string msg);
		$display("%s", msg);
		fail_count++;
	endfunction

	a_instr_done: assert property (@(posedge sys_clk) disable iff (reset)
		instr_accept |=> !done ##1 !done ##1 !done ##1 done)
		else note_failure("done did not pulse on the fourth edge after an instruction");
	a_instr_busy: assert property (@(posedge sys_clk) disable iff (reset)
		instr_accept |=> busy ##1 busy ##1 busy ##1 busy ##1 !busy)
		else note_failure("busy did not stay high for exactly four cycles of an instruction");
	a_done_pulse: assert property (@(posedge sys_clk) disable iff (reset)
		done |=> !done && !busy)
		else note_failure("done lasted more than one cycle or busy did not fall after it");
	a_write_busy: assert property (@(posedge sys_clk) disable iff (reset)
		write_accept |=> busy ##1 !busy)
		else note_failure("busy was not high for exactly one cycle of a host write");
	a_read_timing: assert property (@(posedge sys_clk) disable iff (reset)
		read_accept |=> (busy && !host_rvalid) ##1 host_rvalid)
		else note_failure("host_rvalid did not pulse two edges after a host read");
	a_rvalid_cause: assert property (@(posedge sys_clk) disable iff (reset)
		host_rvalid |-> $past(read_accept, 2))
		else note_failure("host_rvalid pulsed without an accepted host read");
	a_read_data: assert property (@(posedge sys_clk) disable iff (reset)
		host_rvalid |-> host_rdata == rd_model_d2)
		else note_failure($sformatf("Mismatch host_rdata: got 0x%08h, expected 0x%08h",
			$sampled(host_rdata), $sampled(rd_model_d2)));
	a_flags: assert property (@(posedge sys_clk) disable iff (reset)
		done |=> flags == exp_flags)
		else note_failure($sformatf("Mismatch flags: got 0x%0h, expected 0x%0h",
			$sampled(flags), $sampled(exp_flags)));
	a_reset_state: assert property (@(posedge sys_clk)
		reset |=> !busy && !done && !host_rvalid && flags == 3'b000)
		else note_failure("status outputs or flags were not cleared by reset");

	// ~~~~~~~~~~~~~~~~~~~~
	// models and helpers
	// ~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] next_rand();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	// returns {neg, carry, zero, result}.
	function automatic logic [34:0] alu_model(input dsp_pkg::alu_op_t opc,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		logic        c;
		int          n;
		n = b[4:0];
		c = 1'b0;
		case (opc)
			dsp_pkg::OP_MOVE: r = b;
			dsp_pkg::OP_ADD: begin
				r = a + b;
				c = (r < a);  // wrapped past the top.
			end
			dsp_pkg::OP_SUB: begin
				r = a - b;
				c = (a < b);  // borrow.
			end
			dsp_pkg::OP_AND:  r = a & b;
			dsp_pkg::OP_OR:   r = a | b;
			dsp_pkg::OP_XOR:  r = a ^ b;
			dsp_pkg::OP_SHL: begin
				r = a << n;
				if (n != 0) c = a[32 - n];  // last bit out.
			end
			dsp_pkg::OP_SHR: begin
				r = a >> n;
				if (n != 0) c = a[n - 1];
			end
			default: r = b;
		endcase
		return {r[31], c, (r == 32'd0), r};
	endfunction

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (busy && waited < WAIT_LIMIT) begin
			@(posedge sys_clk);
			#1;
			waited++;
		end
		if (busy) note_failure("busy never went low");
	endtask

	task automatic write_reg(input dsp_pkg::reg_addr_t a, input dsp_pkg::reg_data_t v);
		wait_idle();
		host_we    = 1'b1;
		host_addr  = a;
		host_wdata = v;
		@(posedge sys_clk);
		#1;
		host_we  = 1'b0;
		model[a] = v;
	endtask

	task automatic read_reg(input dsp_pkg::reg_addr_t a);
		int waited;
		wait_idle();
		waited    = 0;
		rd_model  = model[a];
		host_rd   = 1'b1;
		host_addr = a;
		@(posedge sys_clk);
		#1;
		host_rd = 1'b0;
		while (!host_rvalid && waited < WAIT_LIMIT) begin
			@(posedge sys_clk);
			#1;
			waited++;
		end
		if (!host_rvalid) note_failure($sformatf("no read data for register %0d", a));
	endtask

	task automatic start_instr(input dsp_pkg::alu_op_t opc, input dsp_pkg::reg_addr_t d,
		input dsp_pkg::reg_addr_t s, output logic [34:0] exp_res);
		wait_idle();
		exp_res     = alu_model(opc, model[d], model[s]);  // old values even when d is s.
		instr_valid = 1'b1;
		op          = opc;
		dst         = d;
		src         = s;
		@(posedge sys_clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic finish_instr(input dsp_pkg::reg_addr_t d, input logic [34:0] exp_res);
		int waited;
		waited = 0;
		while (!done && waited < WAIT_LIMIT) begin
			@(posedge sys_clk);
			#1;
			waited++;
		end
		if (!done) note_failure("done never came for an instruction");
		model[d]  = exp_res[31:0];
		exp_flags = exp_res[34:32];
	endtask

	task automatic run_instr(input dsp_pkg::alu_op_t opc, input dsp_pkg::reg_addr_t d,
		input dsp_pkg::reg_addr_t s);
		logic [34:0] exp_res;
		start_instr(opc, d, s, exp_res);
		finish_instr(d, exp_res);
	endtask

	task automatic check_case(input dsp_pkg::alu_op_t opc, input dsp_pkg::reg_data_t a,
		input dsp_pkg::reg_data_t b, input dsp_pkg::reg_addr_t d, input dsp_pkg::reg_addr_t s);
		write_reg(d, a);
		write_reg(s, b);
		run_instr(opc, d, s);
		read_reg(d);
	endtask

	task automatic report_test(input string name);
		test_count++;
		$display("test %0d %s: %0d failures", test_count, name, fail_count - errs_at_start);
		errs_at_start = fail_count;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [31:0]        r;
		logic [34:0]        exp_res;
		dsp_pkg::reg_addr_t d;
		dsp_pkg::reg_addr_t s;
		sys_clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		op = dsp_pkg::OP_MOVE;
		dst = '0;
		src = '0;
		host_we = 1'b0;
		host_rd = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		rd_model = '0;
		exp_flags = '0;
		rand_state = 32'he18d_a54e;
		fail_count = 0;
		test_count = 0;
		cycle_count = 0;
		errs_at_start = 0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < dsp_pkg::REG_COUNT; i++) begin
			write_reg(dsp_pkg::reg_addr_t'(i), next_rand());
		end
		for (int i = 0; i < dsp_pkg::REG_COUNT; i++) begin
			read_reg(dsp_pkg::reg_addr_t'(i));
		end
		report_test("host_write_read");

		check_case(dsp_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0001, 6'd1, 6'd2);  // carry, zero.
		check_case(dsp_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 6'd3, 6'd4);  // negative.
		check_case(dsp_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000, 6'd5, 6'd6);
		check_case(dsp_pkg::OP_SUB, 32'h0000_0005, 32'h0000_0007, 6'd7, 6'd8);  // borrow.
		check_case(dsp_pkg::OP_SUB, 32'h0000_0007, 32'h0000_0005, 6'd9, 6'd10);
		check_case(dsp_pkg::OP_SUB, 32'h1234_5678, 32'h1234_5678, 6'd11, 6'd12);
		for (int i = 0; i < 8; i++) begin
			check_case((i % 2) ? dsp_pkg::OP_SUB : dsp_pkg::OP_ADD, next_rand(), next_rand(),
				dsp_pkg::reg_addr_t'(13 + i), dsp_pkg::reg_addr_t'(21 + i));
		end
		report_test("arithmetic");

		check_case(dsp_pkg::OP_MOVE, next_rand(), 32'h8000_0001, 6'd30, 6'd31);
		check_case(dsp_pkg::OP_MOVE, next_rand(), 32'h0000_0000, 6'd30, 6'd31);
		check_case(dsp_pkg::OP_AND, 32'hf0f0_f0f0, 32'h0f0f_0f0f, 6'd32, 6'd33);  // zero.
		check_case(dsp_pkg::OP_AND, 32'hffff_0000, 32'h8000_ffff, 6'd32, 6'd33);
		check_case(dsp_pkg::OP_OR, 32'h1234_0000, 32'h0000_5678, 6'd34, 6'd35);
		check_case(dsp_pkg::OP_XOR, 32'h5a5a_5a5a, 32'h5a5a_5a5a, 6'd36, 6'd36);  // d == s.
		check_case(dsp_pkg::OP_XOR, 32'ha5a5_a5a5, 32'hffff_ffff, 6'd36, 6'd37);
		check_case(dsp_pkg::OP_SHL, 32'h8000_0001, 32'h0000_0000, 6'd38, 6'd39);
		check_case(dsp_pkg::OP_SHL, 32'h8000_0001, 32'h0000_0001, 6'd38, 6'd39);
		check_case(dsp_pkg::OP_SHL, 32'h0000_0003, 32'h0000_001f, 6'd38, 6'd39);
		check_case(dsp_pkg::OP_SHL, next_rand(), 32'hffff_ffe4, 6'd38, 6'd39);  // amount 4.
		check_case(dsp_pkg::OP_SHR, 32'h8000_0001, 32'h0000_0000, 6'd40, 6'd41);
		check_case(dsp_pkg::OP_SHR, 32'h8000_0001, 32'h0000_0001, 6'd40, 6'd41);
		check_case(dsp_pkg::OP_SHR, 32'h8000_0000, 32'h0000_001f, 6'd40, 6'd41);
		check_case(dsp_pkg::OP_SHR, 32'h0000_0001, 32'h0000_0001, 6'd40, 6'd41);
		report_test("logic_move_shift");

		for (int i = 0; i < N_RANDOM; i++) begin
			r = next_rand();
			d = r[5:0];
			s = (i % 4 == 0) ? r[5:0] : r[13:8];  // every fourth one with dst equal to src.
			run_instr(dsp_pkg::alu_op_t'(r[18:16]), d, s);
			read_reg(d);
		end
		report_test("instr_timing");

		start_instr(dsp_pkg::OP_ADD, 6'd30, 6'd31, exp_res);
		host_we = 1'b1;  // all three dropped while busy.
		host_rd = 1'b1;
		instr_valid = 1'b1;
		host_addr = 6'd40;
		host_wdata = ~model[40];
		@(posedge sys_clk);
		#1;
		host_we = 1'b0;
		host_rd = 1'b0;
		instr_valid = 1'b0;
		finish_instr(6'd30, exp_res);
		read_reg(6'd40);
		read_reg(6'd30);
		wait_idle();
		host_we = 1'b1;  // loses to the instruction.
		host_addr = 6'd41;
		host_wdata = ~model[41];
		start_instr(dsp_pkg::OP_XOR, 6'd32, 6'd33, exp_res);
		host_we = 1'b0;
		finish_instr(6'd32, exp_res);
		read_reg(6'd41);
		read_reg(6'd32);
		wait_idle();
		r = next_rand();
		host_we = 1'b1;  // write wins, read dropped.
		host_rd = 1'b1;
		host_addr = 6'd42;
		host_wdata = r;
		@(posedge sys_clk);
		#1;
		host_addr = 6'd43;  // still strobing while busy.
		host_wdata = ~model[43];
		@(posedge sys_clk);
		#1;
		host_we = 1'b0;
		host_rd = 1'b0;
		model[42] = r;
		read_reg(6'd42);
		read_reg(6'd43);
		report_test("ignored_strobes");

		start_instr(dsp_pkg::OP_ADD, 6'd50, 6'd51, exp_res);
		@(posedge sys_clk);
		#1;
		reset = 1'b1;  // cuts the instruction off before write-back.
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#1;
		reset = 1'b0;
		exp_flags = '0;
		read_reg(6'd50);
		run_instr(dsp_pkg::OP_SUB, 6'd52, 6'd53);
		read_reg(6'd52);
		report_test("reset_state");

		repeat (4) @(posedge sys_clk);  // let pending checks complete.
		$display("%0d tests, %0d failures, %0d cycles", test_count, fail_count, cycle_count);
		if (fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== logic/dsp_core.sv ====
`timescale 1ns/1ps

module dsp_core (
	input  logic                sys_clk,
	input  logic                reset,
	input  logic                instr_valid,
	input  dsp_pkg::alu_op_t    op,
	input  dsp_pkg::reg_addr_t  dst,
	input  dsp_pkg::reg_addr_t  src,
	input  logic                host_we,
	input  logic                host_rd,
	input  dsp_pkg::reg_addr_t  host_addr,
	input  dsp_pkg::reg_data_t  host_wdata,
	output dsp_pkg::reg_data_t  host_rdata,
	output logic                host_rvalid,
	output logic                busy,
	output logic                done,
	output dsp_pkg::alu_flags_t flags
);

	logic               alu_launch;
	dsp_pkg::alu_op_t   alu_op;
	dsp_pkg::reg_data_t alu_result;

	dsp_regs_if u_regs_if ();  // both ram ports.

	// ~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~
	dsp_sequencer u_sequencer (
		.sys_clk     (sys_clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.op          (op),
		.dst         (dst),
		.src         (src),
		.host_we     (host_we),
		.host_rd     (host_rd),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.busy        (busy),
		.done        (done),
		.alu_launch  (alu_launch),
		.alu_op      (alu_op),
		.alu_result  (alu_result),
		.regs        (u_regs_if.owner)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// datapath
	// ~~~~~~~~~~~~~~~~~~~~
	dsp_regfile u_regfile (
		.sys_clk (sys_clk),
		.regs    (u_regs_if.ram)
	);

	// operands straight from the ram output registers.
	dsp_alu u_alu (
		.sys_clk (sys_clk),
		.reset   (reset),
		.launch  (alu_launch),
		.op      (alu_op),
		.dst_val (u_regs_if.q_a),
		.src_val (u_regs_if.q_b),
		.result  (alu_result),
		.flags   (flags)
	);

endmodule

// ==== logic/dsp_sequencer.sv ====
`timescale 1ns/1ps

module dsp_sequencer (
	input  logic               sys_clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  dsp_pkg::alu_op_t   op,
	input  dsp_pkg::reg_addr_t dst,
	input  dsp_pkg::reg_addr_t src,
	input  logic               host_we,
	input  logic               host_rd,
	input  dsp_pkg::reg_addr_t host_addr,
	input  dsp_pkg::reg_data_t host_wdata,
	output dsp_pkg::reg_data_t host_rdata,
	output logic               host_rvalid,
	output logic               busy,
	output logic               done,
	output logic               alu_launch,
	output dsp_pkg::alu_op_t   alu_op,
	input  dsp_pkg::reg_data_t alu_result,
	dsp_regs_if.owner          regs
);

	dsp_pkg::seq_state_t state;
	logic                exec_late;  // second exec cycle.

	// captured request.
	dsp_pkg::alu_op_t   op_q;
	dsp_pkg::reg_addr_t dst_q;
	dsp_pkg::reg_addr_t addr_b_q;      // src or host address.
	dsp_pkg::reg_data_t wdata_b_q;
	logic               host_is_read;

	logic accept_instr;
	logic accept_host;

	// ~~~~~~~~~~~~~~~~~~~~
	// request acceptance
	// ~~~~~~~~~~~~~~~~~~~~
	// instruction wins over host write, host write over host read.
	assign accept_instr = (state == dsp_pkg::SEQ_IDLE) && instr_valid;
	assign accept_host  = (state == dsp_pkg::SEQ_IDLE) && !instr_valid
		&& (host_we || host_rd);

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state       <= dsp_pkg::SEQ_IDLE;
			exec_late   <= 1'b0;
			host_rvalid <= 1'b0;
		end else begin
			exec_late   <= (state == dsp_pkg::SEQ_EXEC) && !exec_late;
			host_rvalid <= (state == dsp_pkg::SEQ_HOST) && host_is_read;  // q_b loads now.
			case (state)
				dsp_pkg::SEQ_IDLE: begin
					if (accept_instr) begin
						state <= dsp_pkg::SEQ_READ;
					end else if (accept_host) begin
						state <= dsp_pkg::SEQ_HOST;
					end
				end
				dsp_pkg::SEQ_READ: begin
					state <= dsp_pkg::SEQ_EXEC;
				end
				dsp_pkg::SEQ_EXEC: begin
					if (exec_late) begin
						state <= dsp_pkg::SEQ_WRITE;  // result registers at this edge.
					end
				end
				dsp_pkg::SEQ_WRITE: state <= dsp_pkg::SEQ_IDLE;
				dsp_pkg::SEQ_HOST:  state <= dsp_pkg::SEQ_IDLE;
				default:            state <= dsp_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept_instr) begin
			op_q     <= op;
			dst_q    <= dst;
			addr_b_q <= src;
		end else if (accept_host) begin
			addr_b_q     <= host_addr;
			wdata_b_q    <= host_wdata;
			host_is_read <= !host_we;  // write wins over read.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// ram port steering
	// ~~~~~~~~~~~~~~~~~~~~
	// port a reads dst, later writes the alu result back.
	assign regs.addr_a   = dst_q;
	assign regs.wdata_a  = alu_result;
	assign regs.strobe_a = (state == dsp_pkg::SEQ_READ) || (state == dsp_pkg::SEQ_WRITE);
	assign regs.nwe_a    = (state != dsp_pkg::SEQ_WRITE);

	// port b reads src, or serves the host.
	assign regs.addr_b   = addr_b_q;
	assign regs.wdata_b  = wdata_b_q;
	assign regs.strobe_b = (state == dsp_pkg::SEQ_READ) || (state == dsp_pkg::SEQ_HOST);
	assign regs.nwe_b    = !((state == dsp_pkg::SEQ_HOST) && !host_is_read);

	// ~~~~~~~~~~~~~~~~~~~~
	// alu and status
	// ~~~~~~~~~~~~~~~~~~~~
	assign alu_op     = op_q;
	assign alu_launch = (state == dsp_pkg::SEQ_EXEC) && exec_late;

	assign host_rdata = regs.q_b;  // valid with host_rvalid.
	assign busy       = (state != dsp_pkg::SEQ_IDLE);
	assign done       = (state == dsp_pkg::SEQ_WRITE);

endmodule

// ==== logic/dsp_alu.sv ====
`timescale 1ns/1ps

module dsp_alu (
	input  logic                sys_clk,
	input  logic                reset,
	input  logic                launch,
	input  dsp_pkg::alu_op_t    op,
	input  dsp_pkg::reg_data_t  dst_val,
	input  dsp_pkg::reg_data_t  src_val,
	output dsp_pkg::reg_data_t  result,
	output dsp_pkg::alu_flags_t flags
);

	dsp_pkg::shamt_t    shamt;
	dsp_pkg::reg_data_t res_next;
	logic               carry_next;
	dsp_pkg::alu_flags_t flags_next;

	// 33 bit intermediates, the extra bit catches carry or shifted-out bit.
	logic [dsp_pkg::DATA_W:0] sum_ext;
	logic [dsp_pkg::DATA_W:0] diff_ext;
	logic [dsp_pkg::DATA_W:0] shl_ext;
	logic [dsp_pkg::DATA_W:0] shr_ext;

	assign shamt = src_val[dsp_pkg::SHAMT_W-1:0];

	assign sum_ext  = {1'b0, dst_val} + {1'b0, src_val};
	assign diff_ext = {1'b0, dst_val} - {1'b0, src_val};  // msb is the borrow.
	assign shl_ext  = {1'b0, dst_val} << shamt;
	assign shr_ext  = {dst_val, 1'b0} >> shamt;

	// ~~~~~~~~~~~~~~~~~~~~
	// next result
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		res_next   = src_val;
		carry_next = 1'b0;
		case (op)
			dsp_pkg::OP_MOVE: begin
				res_next = src_val;
			end
			dsp_pkg::OP_ADD: begin
				res_next   = sum_ext[dsp_pkg::DATA_W-1:0];
				carry_next = sum_ext[dsp_pkg::DATA_W];
			end
			dsp_pkg::OP_SUB: begin
				res_next   = diff_ext[dsp_pkg::DATA_W-1:0];
				carry_next = diff_ext[dsp_pkg::DATA_W];
			end
			dsp_pkg::OP_AND: res_next = dst_val & src_val;
			dsp_pkg::OP_OR:  res_next = dst_val | src_val;
			dsp_pkg::OP_XOR: res_next = dst_val ^ src_val;
			dsp_pkg::OP_SHL: begin
				res_next   = shl_ext[dsp_pkg::DATA_W-1:0];
				carry_next = shl_ext[dsp_pkg::DATA_W];  // zero when shamt is 0.
			end
			dsp_pkg::OP_SHR: begin
				res_next   = shr_ext[dsp_pkg::DATA_W:1];
				carry_next = shr_ext[0];  // zero when shamt is 0.
			end
			default: begin
				res_next   = src_val;
				carry_next = 1'b0;
			end
		endcase
	end

	always_comb begin
		flags_next                      = '0;
		flags_next[dsp_pkg::FLAG_ZERO]  = (res_next == '0);
		flags_next[dsp_pkg::FLAG_CARRY] = carry_next;
		flags_next[dsp_pkg::FLAG_NEG]   = res_next[dsp_pkg::DATA_W-1];
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// output registers
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (launch) begin
			result <= res_next;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			flags <= '0;
		end else if (launch) begin
			flags <= flags_next;  // held until next launch.
		end
	end

endmodule

// ==== logic/dsp_regfile.sv ====
`timescale 1ns/1ps

module dsp_regfile (
	input  logic     sys_clk,
	dsp_regs_if.ram  regs
);

	// ~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~
	dsp_pkg::reg_data_t mem [0:dsp_pkg::REG_COUNT-1];

	dsp_pkg::reg_data_t q_a_r;  // port a output register.
	dsp_pkg::reg_data_t q_b_r;  // port b output register.

	assign regs.q_a = q_a_r;
	assign regs.q_b = q_b_r;

	// ~~~~~~~~~~~~~~~~~~~~
	// both ports
	// ~~~~~~~~~~~~~~~~~~~~
	// each port acts only on its own strobe. a strobed read returns the
	// word as it was before the edge, so a write on the same port shows
	// the old contents. same-address access across ports is left open.
	always_ff @(posedge sys_clk) begin
		if (regs.strobe_a) begin
			if (!regs.nwe_a) begin
				mem[regs.addr_a] <= regs.wdata_a;  // write a.
			end
			q_a_r <= mem[regs.addr_a];  // old word.
		end

		if (regs.strobe_b) begin
			if (!regs.nwe_b) begin
				mem[regs.addr_b] <= regs.wdata_b;  // write b.
			end
			q_b_r <= mem[regs.addr_b];  // old word.
		end
	end

endmodule

// ==== logic/dsp_regs_if.sv ====
`timescale 1ns/1ps

interface dsp_regs_if;

	// port a.
	dsp_pkg::reg_addr_t addr_a;
	dsp_pkg::reg_data_t wdata_a;
	logic               nwe_a;
	logic               strobe_a;
	dsp_pkg::reg_data_t q_a;

	// port b, same shape.
	dsp_pkg::reg_addr_t addr_b;
	dsp_pkg::reg_data_t wdata_b;
	logic               nwe_b;
	logic               strobe_b;
	dsp_pkg::reg_data_t q_b;

	modport owner (
		output addr_a, wdata_a, nwe_a, strobe_a,
		output addr_b, wdata_b, nwe_b, strobe_b,
		input  q_a, q_b
	);

	modport ram (
		input  addr_a, wdata_a, nwe_a, strobe_a,
		input  addr_b, wdata_b, nwe_b, strobe_b,
		output q_a, q_b
	);

endinterface

// ==== logic/dsp_pkg.sv ====
package dsp_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int ADDR_W    = 6;   // register number.
	localparam int DATA_W    = 32;  // data word.
	localparam int SHAMT_W   = 5;   // shift amount taken from src.
	localparam int REG_COUNT = 64;  // registers in the file.

	// bit positions inside alu_flags_t.
	localparam int FLAG_ZERO  = 0;
	localparam int FLAG_CARRY = 1;
	localparam int FLAG_NEG   = 2;

	// ~~~~~~~~~~~~~~~~~~~~
	// vector types
	// ~~~~~~~~~~~~~~~~~~~~
	typedef logic [ADDR_W-1:0]  reg_addr_t;
	typedef logic [DATA_W-1:0]  reg_data_t;
	typedef logic [SHAMT_W-1:0] shamt_t;
	typedef logic [2:0]         alu_flags_t;   // {neg, carry, zero}.

	// ~~~~~~~~~~~~~~~~~~~~
	// opcodes and states
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		OP_MOVE = 3'd0,  // dst = src.
		OP_ADD  = 3'd1,
		OP_SUB  = 3'd2,
		OP_AND  = 3'd3,
		OP_OR   = 3'd4,
		OP_XOR  = 3'd5,
		OP_SHL  = 3'd6,
		OP_SHR  = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		SEQ_IDLE  = 3'd0,
		SEQ_READ  = 3'd1,  // both ports strobed.
		SEQ_EXEC  = 3'd2,  // operands settle, then alu launch.
		SEQ_WRITE = 3'd3,  // write-back on port a.
		SEQ_HOST  = 3'd4   // host access on port b.
	} seq_state_t;

endpackage
